// File: Bender.yml
package:
  name: lsu

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/lsu_access_pkg.sv
      - logic/lsu_bus_pkg.sv
      - logic/lsu_req_gen.sv
      - logic/lsu_outstanding_ctrl.sv
      - logic/lsu_rdata_align.sv
      - logic/lsu_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verif/lsu_assertions.sv
      - verif/lsu_tb.sv

// File: all.f
+incdir+logic
logic/lsu_access_pkg.sv
logic/lsu_bus_pkg.sv
logic/lsu_req_gen.sv
logic/lsu_outstanding_ctrl.sv
logic/lsu_rdata_align.sv
logic/lsu_top.sv
verif/lsu_assertions.sv
verif/lsu_tb.sv

// File: logic/lsu_access_pkg.sv
// access descriptors coming from the execute stage
// encodings follow the core's decoder, unlisted codes are decoded by the lsu
`default_nettype none

package lsu_access_pkg;

  // access size, code 2'b11 is decoded as a byte access
  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00,  // 32 bit
    SIZE_HALF = 2'b01,  // 16 bit
    SIZE_BYTE = 2'b10   // 8 bit
  } access_size_e;

  // extension of sub-word loads, code 2'b11 acts as EXT_SIGN
  typedef enum logic [1:0] {
    EXT_ZERO = 2'b00,  // fill with zeros
    EXT_SIGN = 2'b01,  // replicate msb of loaded item
    EXT_ONES = 2'b10   // fill with ones
  } ext_mode_e;

endpackage

`default_nettype wire

// File: logic/lsu_bus_pkg.sv
// data bus types, widths come from the lsu macro header
`default_nettype none

`include "lsu_macros.svh"

package lsu_bus_pkg;

  typedef logic [`LSU_XLEN-1:0] bus_word_t;  // read/write data
  typedef logic [`LSU_XLEN-1:0] bus_addr_t;  // byte address
  typedef logic [`LSU_BE_W-1:0] bus_be_t;    // byte lane enables

endpackage

`default_nettype wire

// File: logic/lsu_macros.svh
// widths and limits shared by the load/store unit and its testbench
// the unit only supports a 32-bit bus with 4 byte lanes
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// data and address width
`define LSU_XLEN   32

// one enable per byte lane
`define LSU_BE_W   4

// byte offset inside a bus word
`define LSU_OFFS_W 2

// outstanding transactions on the data bus, counter must hold this value
`define LSU_DEPTH  2
`define LSU_CNT_W  2

`endif

// File: logic/lsu_outstanding_ctrl.sv
// outstanding transaction bookkeeping and handshake towards ex/wb
// assumes rvalid comes at least one cycle after its grant, in grant order
// data_req_o depends combinationally on data_req_ex_i and the count only
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_outstanding_ctrl (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic data_req_ex_i,   // ex stage wants a transfer
  input  wire logic data_gnt_i,
  input  wire logic data_rvalid_i,
  output logic      data_req_o,
  output logic      lsu_ready_ex_o,
  output logic      lsu_ready_wb_o,
  output logic      busy_o,
  output logic      ctrl_update_o    // ex request accepted, wb control moves
);

  localparam logic [`LSU_CNT_W-1:0] CNT_MAX = `LSU_DEPTH;
  localparam logic [`LSU_CNT_W-1:0] CNT_ONE = 1;

  logic [`LSU_CNT_W-1:0] cnt_q;       // transactions granted but not answered
  logic [`LSU_CNT_W-1:0] cnt_d;
  logic                  count_up;    // request granted this cycle
  logic                  count_down;  // response arrived this cycle

  ////////////////////////////////////////////////////////////////////////////
  // request gating

  assign data_req_o = data_req_ex_i && (cnt_q < CNT_MAX);
  assign count_up   = data_req_o && data_gnt_i;
  assign count_down = data_rvalid_i;

  // wb is free when idle, otherwise only when its response shows up
  assign lsu_ready_wb_o = (cnt_q == '0) ? 1'b1 : data_rvalid_i;

  // ex and wb advance in lock step
  always_comb begin
    if (!data_req_ex_i) begin
      lsu_ready_ex_o = 1'b1;                      // nothing to do
    end else if (cnt_q == '0) begin
      lsu_ready_ex_o = count_up;                  // wb empty, grant is enough
    end else if (cnt_q == CNT_ONE) begin
      lsu_ready_ex_o = count_up && data_rvalid_i; // wb must drain together
    end else begin
      lsu_ready_ex_o = data_rvalid_i;             // already granted, wait for slot
    end
  end

  assign ctrl_update_o = lsu_ready_ex_o && data_req_ex_i;
  assign busy_o        = (cnt_q != '0) || data_req_o;

  ////////////////////////////////////////////////////////////////////////////
  // counter

  always_comb begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;          // idle, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

endmodule

`default_nettype wire

// File: logic/lsu_rdata_align.sv
// load data alignment and extension, zero added latency on rvalid
// control is sampled when ex hands the request over, one set of registers
// so only the oldest outstanding access may be answered next
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_rdata_align (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic                         ctrl_update_i,  // ex request accepted
  input  wire lsu_access_pkg::access_size_e data_type_i,
  input  wire lsu_access_pkg::ext_mode_e    data_sign_ext_i,
  input  wire logic [`LSU_OFFS_W-1:0]       addr_offs_i,
  input  wire logic                         data_we_i,
  input  wire logic                         split_first_i,  // first half of a split
  input  wire logic                         resp_valid_i,
  input  wire lsu_bus_pkg::bus_word_t       resp_rdata_i,
  output lsu_bus_pkg::bus_word_t            data_rdata_o
);

  lsu_access_pkg::access_size_e type_q;
  lsu_access_pkg::ext_mode_e    ext_q;
  logic [`LSU_OFFS_W-1:0]       offs_q;
  logic                         we_q;
  logic                         first_q;   // response is the low word of a split

  lsu_bus_pkg::bus_word_t       rdata_q;   // previous word or last result
  logic [2*`LSU_XLEN-1:0]       joined;    // {new word, previous word}
  lsu_bus_pkg::bus_word_t       word_ext;
  lsu_bus_pkg::bus_word_t       half_ext;
  lsu_bus_pkg::bus_word_t       byte_ext;
  lsu_bus_pkg::bus_word_t       rdata_ext;
  logic [15:0]                  half_sel;
  logic [7:0]                   byte_sel;

  // upper fill bit for the extension mode, 2'b11 behaves as sign
  function automatic logic fill_bit(lsu_access_pkg::ext_mode_e mode, logic msb);
    case (mode)
      lsu_access_pkg::EXT_ZERO: fill_bit = 1'b0;
      lsu_access_pkg::EXT_ONES: fill_bit = 1'b1;
      default:                  fill_bit = msb;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // control capture

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      type_q  <= lsu_access_pkg::SIZE_WORD;
      ext_q   <= lsu_access_pkg::EXT_ZERO;
      offs_q  <= '0;
      we_q    <= 1'b0;
      first_q <= 1'b0;
    end else if (ctrl_update_i) begin
      type_q  <= data_type_i;
      ext_q   <= data_sign_ext_i;
      offs_q  <= addr_offs_i;
      we_q    <= data_we_i;
      first_q <= split_first_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // alignment

  // a split access takes its low bytes from the saved first word
  assign joined = {resp_rdata_i, rdata_q};

  always_comb begin
    case (offs_q)
      2'd0:    word_ext = resp_rdata_i;
      2'd1:    word_ext = joined[39:8];
      2'd2:    word_ext = joined[47:16];
      default: word_ext = joined[55:24];
    endcase
  end

  always_comb begin
    case (offs_q)
      2'd0:    half_sel = resp_rdata_i[15:0];
      2'd1:    half_sel = resp_rdata_i[23:8];
      2'd2:    half_sel = resp_rdata_i[31:16];
      default: half_sel = joined[39:24];       // crosses into next word
    endcase
  end

  assign byte_sel = resp_rdata_i[8*offs_q +: 8];

  assign half_ext = {{16{fill_bit(ext_q, half_sel[15])}}, half_sel};
  assign byte_ext = {{24{fill_bit(ext_q, byte_sel[7])}}, byte_sel};

  always_comb begin
    case (type_q)
      lsu_access_pkg::SIZE_WORD: rdata_ext = word_ext;
      lsu_access_pkg::SIZE_HALF: rdata_ext = half_ext;
      default:                   rdata_ext = byte_ext;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // result hold

  // raw word after a first half, the finished value otherwise
  always_ff @(posedge clk) begin
    if (resp_valid_i && !we_q) begin
      rdata_q <= first_q ? resp_rdata_i : rdata_ext;
    end
  end

  assign data_rdata_o = resp_valid_i ? rdata_ext : rdata_q;

endmodule

`default_nettype wire

// File: logic/lsu_req_gen.sv
// address-phase generation for the data bus
// purely combinational, a misaligned access is split into two phases
// by the execute stage, this block only flags the first one
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_req_gen (
  input  wire lsu_bus_pkg::bus_addr_t     operand_a_i,
  input  wire lsu_bus_pkg::bus_addr_t     operand_b_i,
  input  wire logic                       addr_useincr_i,     // a + b, else a
  input  wire lsu_access_pkg::access_size_e data_type_i,
  input  wire lsu_bus_pkg::bus_word_t     data_wdata_i,
  input  wire logic [`LSU_OFFS_W-1:0]     data_reg_offset_i,  // byte offset in register
  input  wire logic                       data_req_i,
  input  wire logic                       data_misaligned_ex_i, // second phase in ex
  output lsu_bus_pkg::bus_addr_t          addr_o,
  output lsu_bus_pkg::bus_be_t            be_o,
  output lsu_bus_pkg::bus_word_t          wdata_o,
  output logic [`LSU_OFFS_W-1:0]          addr_offs_o,
  output logic                            data_misaligned_o
);

  lsu_bus_pkg::bus_addr_t     addr_int;     // unaligned effective address
  logic [`LSU_OFFS_W-1:0]     addr_offs;
  logic [`LSU_OFFS_W-1:0]     wdata_offs;   // rotation amount in bytes

  ////////////////////////////////////////////////////////////////////////////
  // address

  assign addr_int  = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign addr_offs = addr_int[`LSU_OFFS_W-1:0];

  // second phase always starts at lane 0 of the next word
  assign addr_o      = data_misaligned_ex_i ? {addr_int[`LSU_XLEN-1:`LSU_OFFS_W], 2'b00}
                                            : addr_int;
  assign addr_offs_o = addr_offs;  // raw offset, used again for load alignment

  ////////////////////////////////////////////////////////////////////////////
  // byte enables

  always_comb begin
    case (data_type_i)
      lsu_access_pkg::SIZE_WORD: begin
        if (!data_misaligned_ex_i) begin
          be_o = 4'b1111 << addr_offs;     // lanes from offset upward
        end else begin
          be_o = ~(4'b1111 << addr_offs);  // leftover low lanes
        end
      end
      lsu_access_pkg::SIZE_HALF: begin
        if (!data_misaligned_ex_i) begin
          be_o = 4'b0011 << addr_offs;     // offset 3 keeps lane 3 only
        end else begin
          be_o = 4'b0001;                  // upper byte of a split half
        end
      end
      default: begin                       // byte, also code 2'b11
        be_o = 4'b0001 << addr_offs;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // store data rotation

  // register lane offset is subtracted, wraps mod 4
  assign wdata_offs = addr_offs - data_reg_offset_i;

  always_comb begin
    case (wdata_offs)
      2'd0:    wdata_o = data_wdata_i;
      2'd1:    wdata_o = {data_wdata_i[23:0], data_wdata_i[31:24]};
      2'd2:    wdata_o = {data_wdata_i[15:0], data_wdata_i[31:16]};
      default: wdata_o = {data_wdata_i[7:0],  data_wdata_i[31:8]};
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // misalignment

  // only a first phase can cross a word boundary
  always_comb begin
    data_misaligned_o = 1'b0;
    if (data_req_i && !data_misaligned_ex_i) begin
      case (data_type_i)
        lsu_access_pkg::SIZE_WORD: data_misaligned_o = (addr_offs != 2'b00);
        lsu_access_pkg::SIZE_HALF: data_misaligned_o = (addr_offs == 2'b11);
        default:                   data_misaligned_o = 1'b0;  // bytes never split
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/lsu_top.sv
// data-side load/store unit with a req/gnt/rvalid bus
// no bus errors, no atomics; ex stage must hold its inputs until ready
// and issue the second phase itself when data_misaligned_o is seen
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_top (
  input  wire logic                         clk,
  input  wire logic                         rst_n,

  // execute stage
  input  wire logic                         data_req_ex_i,
  input  wire logic                         data_we_ex_i,
  input  wire lsu_access_pkg::access_size_e data_type_ex_i,
  input  wire lsu_access_pkg::ext_mode_e    data_sign_ext_ex_i,
  input  wire lsu_bus_pkg::bus_word_t       data_wdata_ex_i,
  input  wire logic [`LSU_OFFS_W-1:0]       data_reg_offset_ex_i,
  input  wire lsu_bus_pkg::bus_addr_t       operand_a_ex_i,
  input  wire lsu_bus_pkg::bus_addr_t       operand_b_ex_i,
  input  wire logic                         addr_useincr_ex_i,
  input  wire logic                         data_misaligned_ex_i,
  output lsu_bus_pkg::bus_word_t            data_rdata_ex_o,
  output logic                              data_misaligned_o,
  output logic                              lsu_ready_ex_o,
  output logic                              lsu_ready_wb_o,
  output logic                              busy_o,

  // data bus
  output logic                              data_req_o,
  input  wire logic                         data_gnt_i,
  output lsu_bus_pkg::bus_addr_t            data_addr_o,
  output logic                              data_we_o,
  output lsu_bus_pkg::bus_be_t              data_be_o,
  output lsu_bus_pkg::bus_word_t            data_wdata_o,
  input  wire logic                         data_rvalid_i,
  input  wire lsu_bus_pkg::bus_word_t       data_rdata_i
);

  logic [`LSU_OFFS_W-1:0] addr_offs;    // low bits of the effective address
  logic                   ctrl_update;  // ex request handed to wb

  // address phase goes straight to the bus, ex keeps it stable until grant
  lsu_req_gen u_req_gen (
    .operand_a_i          (operand_a_ex_i),
    .operand_b_i          (operand_b_ex_i),
    .addr_useincr_i       (addr_useincr_ex_i),
    .data_type_i          (data_type_ex_i),
    .data_wdata_i         (data_wdata_ex_i),
    .data_reg_offset_i    (data_reg_offset_ex_i),
    .data_req_i           (data_req_ex_i),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .addr_o               (data_addr_o),
    .be_o                 (data_be_o),
    .wdata_o              (data_wdata_o),
    .addr_offs_o          (addr_offs),
    .data_misaligned_o    (data_misaligned_o)
  );

  assign data_we_o = data_we_ex_i;

  lsu_outstanding_ctrl u_outstanding_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_req_o     (data_req_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o),
    .ctrl_update_o  (ctrl_update)
  );

  // response side, rvalid is used as is
  lsu_rdata_align u_rdata_align (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctrl_update_i   (ctrl_update),
    .data_type_i     (data_type_ex_i),
    .data_sign_ext_i (data_sign_ext_ex_i),
    .addr_offs_i     (addr_offs),
    .data_we_i       (data_we_ex_i),
    .split_first_i   (data_misaligned_o),
    .resp_valid_i    (data_rvalid_i),
    .resp_rdata_i    (data_rdata_i),
    .data_rdata_o    (data_rdata_ex_o)
  );

endmodule

`default_nettype wire

// File: verif/lsu_assertions.sv
// bus protocol and counter properties, bound into lsu_top
// relies on the internal counter name of the outstanding controller
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_assertions (
  input wire logic                   clk,
  input wire logic                   rst_n,
  input wire logic [`LSU_CNT_W-1:0]  cnt_i,        // outstanding count
  input wire logic                   data_req_i,
  input wire logic                   data_gnt_i,
  input wire logic                   data_rvalid_i,
  input wire lsu_bus_pkg::bus_addr_t data_addr_i,
  input wire logic                   data_we_i,
  input wire lsu_bus_pkg::bus_be_t   data_be_i,
  input wire lsu_bus_pkg::bus_word_t data_wdata_i
);

  int unsigned assert_fails = 0;  // failed assertions so far

  a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_i <= `LSU_DEPTH)
    else begin
      assert_fails++;
      $error("outstanding count %0d above limit", cnt_i);
    end

  // a response needs a granted transaction
  a_no_spurious_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> cnt_i != '0)
    else begin
      assert_fails++;
      $error("rvalid with no outstanding transaction");
    end

  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_i && !data_gnt_i |=> data_req_i && $stable(data_addr_i) &&
      $stable(data_we_i) && $stable(data_be_i) && $stable(data_wdata_i))
    else begin
      assert_fails++;
      $error("address phase changed before grant");
    end

endmodule

bind lsu_top lsu_assertions u_assertions (
  .clk           (clk),
  .rst_n         (rst_n),
  .cnt_i         (u_outstanding_ctrl.cnt_q),
  .data_req_i    (data_req_o),
  .data_gnt_i    (data_gnt_i),
  .data_rvalid_i (data_rvalid_i),
  .data_addr_i   (data_addr_o),
  .data_we_i     (data_we_o),
  .data_be_i     (data_be_o),
  .data_wdata_i  (data_wdata_o)
);

`default_nettype wire

// File: verif/lsu_tb.sv
// random execute-stage traffic against an in-order bus responder and memory model
// register offset is held at zero and accesses stay inside a 256-byte window
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_tb;

  localparam int NUM_OPS     = 400;
  localparam int CYCLE_LIMIT = NUM_OPS * 40;  // 40 cycles per operation
  localparam int SAMPLE_DLY  = 40;            // after the falling edge and before the rise

  // one accepted phase as seen from the execute stage
  typedef struct packed {
    logic        we;
    logic        final_load;  // load result is due in this response
    logic [5:0]  word;        // word index of this phase
    logic [3:0]  be;
    logic [31:0] wdata;
    logic [7:0]  addr;        // start byte of the whole access
    logic [2:0]  nbytes;
    logic [1:0]  ext;
  } exp_t;

  // one granted bus transaction
  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic [31:0] due;         // cycle of its rvalid
  } txn_t;

  logic clk;
  logic rst_n;
  logic data_req_ex;
  logic data_we_ex;
  logic addr_useincr_ex;
  logic data_misaligned_ex;
  logic [`LSU_OFFS_W-1:0]       data_reg_offset_ex;
  lsu_access_pkg::access_size_e data_type_ex;
  lsu_access_pkg::ext_mode_e    data_sign_ext_ex;
  lsu_bus_pkg::bus_word_t       data_wdata_ex;
  lsu_bus_pkg::bus_addr_t       operand_a_ex;
  lsu_bus_pkg::bus_addr_t       operand_b_ex;
  lsu_bus_pkg::bus_word_t       data_rdata_ex;
  logic data_misaligned;
  logic lsu_ready_ex;
  logic lsu_ready_wb;
  logic busy;
  logic data_req;
  logic data_gnt;
  logic data_we;
  logic data_rvalid;
  lsu_bus_pkg::bus_addr_t       data_addr;
  lsu_bus_pkg::bus_be_t         data_be;
  lsu_bus_pkg::bus_word_t       data_wdata;
  lsu_bus_pkg::bus_word_t       data_rdata;

  lsu_bus_pkg::bus_word_t bus_mem [64];    // what the bus slave holds
  lsu_bus_pkg::bus_word_t model_mem [64];  // expected contents
  exp_t exp_q [$];
  txn_t txn_q [$];
  int   errors = 0;
  int   checks = 0;
  int   cycle = 0;

  // current operation, shared by both phases
  logic        op_we;
  logic [1:0]  op_size;
  logic [1:0]  op_ext;
  logic [7:0]  op_addr;
  logic [31:0] op_wdata;
  int          op_nbytes;

  lsu_top dut (
    .clk (clk), .rst_n (rst_n),
    .data_req_ex_i (data_req_ex), .data_we_ex_i (data_we_ex),
    .data_type_ex_i (data_type_ex), .data_sign_ext_ex_i (data_sign_ext_ex),
    .data_wdata_ex_i (data_wdata_ex), .data_reg_offset_ex_i (data_reg_offset_ex),
    .operand_a_ex_i (operand_a_ex), .operand_b_ex_i (operand_b_ex),
    .addr_useincr_ex_i (addr_useincr_ex), .data_misaligned_ex_i (data_misaligned_ex),
    .data_rdata_ex_o (data_rdata_ex), .data_misaligned_o (data_misaligned),
    .lsu_ready_ex_o (lsu_ready_ex), .lsu_ready_wb_o (lsu_ready_wb), .busy_o (busy),
    .data_req_o (data_req), .data_gnt_i (data_gnt), .data_addr_o (data_addr),
    .data_we_o (data_we), .data_be_o (data_be), .data_wdata_o (data_wdata),
    .data_rvalid_i (data_rvalid), .data_rdata_i (data_rdata)
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic logic [31:0] fill_word(input int i);
    logic [31:0] a;
    a = i;
    return (a * 32'h9e37_79b9) ^ {a[15:0], ~a[15:0]};  // every address bit counts
  endfunction

  // lane k carries access byte j, enabled when j lies inside the access
  function automatic logic [3:0] lane_enables(input int offs, input int nbytes,
                                              input logic second);
    int j;
    lane_enables = 4'b0000;
    for (int k = 0; k < 4; k++) begin
      j = second ? k + 4 - offs : k - offs;
      if (j >= 0 && j < nbytes) begin
        lane_enables[k] = 1'b1;
      end
    end
  endfunction

  function automatic logic [31:0] rotate_lanes(input logic [31:0] w, input int offs);
    for (int k = 0; k < 4; k++) begin
      rotate_lanes[8*k +: 8] = w[8*((k - offs + 4) % 4) +: 8];
    end
  endfunction

  function automatic logic [31:0] extend(input logic [31:0] raw, input int nbytes,
                                         input logic [1:0] ext);
    logic fill;
    fill = (ext == 2'b00) ? 1'b0 : (ext == 2'b10) ? 1'b1 : raw[8*nbytes-1];
    extend = raw;
    for (int k = 8 * nbytes; k < 32; k++) begin
      extend[k] = fill;
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // clock and watchdog

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    while (cycle <= CYCLE_LIMIT) begin
      @(posedge clk);
      cycle++;
    end
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("CHECKS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus responder grants after 0..2 cycles and answers 1..3 cycles later in order

  initial begin : responder
    txn_t t;
    int   gnt_delay;
    int   owed;                               // granted and not yet answered
    logic [31:0] last_due;
    last_due  = '0;
    wait (rst_n === 1'b1);
    gnt_delay = $urandom_range(2);
    forever begin
      @(negedge clk);
      owed        = txn_q.size();
      data_gnt    = (gnt_delay == 0);
      data_rvalid = 1'b0;
      if (txn_q.size() != 0 && txn_q[0].due <= cycle) begin
        t = txn_q.pop_front();
        data_rvalid = 1'b1;
        if (t.we) begin
          for (int k = 0; k < 4; k++) begin
            if (t.be[k]) begin
              bus_mem[t.addr[7:2]][8*k +: 8] = t.wdata[8*k +: 8];
            end
          end
          data_rdata = $urandom;              // don't care on stores
        end else begin
          data_rdata = bus_mem[t.addr[7:2]];
        end
      end
      #SAMPLE_DLY;
      if (txn_q.size() != 0) begin
        check_value("busy while responses owed", 1, busy);
      end
      // wb is free when nothing is owed, otherwise only with a response
      check_value("wb ready", (owed == 0) ? 1 : data_rvalid, lsu_ready_wb);
      if (data_req && data_gnt) begin
        t.we    = data_we;
        t.addr  = data_addr;
        t.be    = data_be;
        t.wdata = data_wdata;
        t.due   = cycle + $urandom_range(3, 1);
        if (t.due <= last_due) begin
          t.due = last_due + 1;               // keep responses in grant order
        end
        last_due = t.due;
        txn_q.push_back(t);
        gnt_delay = $urandom_range(2);
      end else if (data_req && gnt_delay > 0) begin
        gnt_delay--;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // response checker keeps the model memory in step with the expected store data

  initial begin : response_check
    exp_t e;
    logic [31:0] raw;
    logic [7:0]  a;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      #SAMPLE_DLY;
      if (data_rvalid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("response arrived while no accepted request was pending");
        end else begin
          e = exp_q.pop_front();
          if (e.we) begin
            for (int k = 0; k < 4; k++) begin
              if (e.be[k]) begin
                model_mem[e.word][8*k +: 8] = e.wdata[8*k +: 8];
              end
            end
            check_value("stored memory word", model_mem[e.word], bus_mem[e.word]);
          end else if (e.final_load) begin
            raw = '0;
            for (int k = 0; k < e.nbytes; k++) begin
              a = e.addr + k;                 // may run into the next word
              raw[8*k +: 8] = model_mem[a[7:2]][8*a[1:0] +: 8];
            end
            check_value("load data", extend(raw, e.nbytes, e.ext), data_rdata_ex);
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // execute-stage driver

  // called at a falling edge, returns at the falling edge after acceptance
  task automatic drive_phase(input logic second, input logic exp_mis);
    logic [31:0] addr;
    logic [31:0] b;
    logic [3:0]  exp_be;
    logic [31:0] exp_wdata;
    logic        done;
    exp_t        e;
    addr      = second ? op_addr + 32'd4 : {24'h0, op_addr};
    exp_be    = lane_enables(op_addr[1:0], op_nbytes, second);
    exp_wdata = rotate_lanes(op_wdata, op_addr[1:0]);
    b         = $urandom_range(15);
    data_req_ex        = 1'b1;
    data_we_ex         = op_we;
    data_type_ex       = lsu_access_pkg::access_size_e'(op_size);
    data_sign_ext_ex   = lsu_access_pkg::ext_mode_e'(op_ext);
    data_wdata_ex      = op_wdata;
    addr_useincr_ex    = $urandom_range(1);
    operand_b_ex       = b;
    operand_a_ex       = addr_useincr_ex ? addr - b : addr;
    data_misaligned_ex = second;
    done = 1'b0;
    while (!done) begin
      #SAMPLE_DLY;
      if (data_req) begin                     // same values every cycle until grant
        check_value("bus address", second ? {addr[31:2], 2'b00} : addr, data_addr);
        check_value("bus byte enable", exp_be, data_be);
        check_value("bus write enable", op_we, data_we);
        if (op_we) begin
          check_value("bus write data", exp_wdata, data_wdata);
        end
        if (!data_gnt) begin
          check_value("ex ready under back-pressure", 0, lsu_ready_ex);
        end
      end
      if (lsu_ready_ex) begin
        check_value("misaligned flag", exp_mis, data_misaligned);
        e.we         = op_we;
        e.final_load = !op_we && !exp_mis;
        e.word       = addr[7:2];
        e.be         = exp_be;
        e.wdata      = exp_wdata;
        e.addr       = op_addr;
        e.nbytes     = op_nbytes;
        e.ext        = op_ext;
        exp_q.push_back(e);
        done = 1'b1;
      end
      @(negedge clk);
    end
  endtask

  task automatic run_op();
    logic mis;
    int   idle;
    op_we     = $urandom_range(1);
    op_size   = $urandom_range(3);            // 2'b11 is a byte too
    op_ext    = $urandom_range(3);
    op_nbytes = (op_size == 2'b00) ? 4 : (op_size == 2'b01) ? 2 : 1;
    op_addr   = $urandom_range(251);          // second phase stays in the window
    op_wdata  = $urandom;
    mis = (op_nbytes == 4 && op_addr[1:0] != 2'b00) ||
          (op_nbytes == 2 && op_addr[1:0] == 2'b11);
    drive_phase(1'b0, mis);
    if (mis) begin
      drive_phase(1'b1, 1'b0);
    end
    data_req_ex = 1'b0;
    idle = $urandom_range(2);
    repeat (idle) @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin : main
    void'($urandom(32'h4c98_5b61));
    rst_n              = 1'b0;
    data_req_ex        = 1'b0;
    data_we_ex         = 1'b0;
    data_type_ex       = lsu_access_pkg::SIZE_WORD;
    data_sign_ext_ex   = lsu_access_pkg::EXT_ZERO;
    data_wdata_ex      = '0;
    data_reg_offset_ex = '0;
    operand_a_ex       = '0;
    operand_b_ex       = '0;
    addr_useincr_ex    = 1'b0;
    data_misaligned_ex = 1'b0;
    data_gnt           = 1'b0;
    data_rvalid        = 1'b0;
    data_rdata         = '0;
    for (int i = 0; i < 64; i++) begin
      bus_mem[i]   = fill_word(i);
      model_mem[i] = fill_word(i);
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #SAMPLE_DLY;
    check_value("busy after reset", 0, busy);
    check_value("bus request after reset", 0, data_req);
    check_value("wb ready after reset", 1, lsu_ready_wb);
    @(negedge clk);
    for (int n = 0; n < NUM_OPS; n++) begin
      run_op();
    end
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
    $display("operations: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
             NUM_OPS, checks, errors, dut.u_assertions.assert_fails);
    if (errors == 0 && dut.u_assertions.assert_fails == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
